// ==== hw/bank_decoder.sv ====
// request decoder, maps a master access onto one bank enable or a miss pulse
`timescale 1ns/100ps

module bank_decoder import mem_pkg::*; (
   input  logic               mig_clk,
   input  logic               rst_i,
   input  logic               req_i,
   input  mem_op_e            op_i,
   input  addr_t              addr_i,
   input  data_t              wdata_i,
   input  strb_t              strb_i,
   input  logic               release_i,
   output logic [N_BANKS-1:0] bank_en_o,
   output strb_t              bank_we_o,
   output word_idx_t          bank_word_o,
   output data_t              bank_wdata_o,
   output logic               miss_o
);

   dec_state_e state;
   logic       mapped;
   logic       start;
   bank_idx_t  bank_sel;
   word_idx_t  word_sel;

   // map rule
   assign mapped   = (addr_i & MAP_MASK) == '0;
   assign bank_sel = addr_i[BANK_SEL_LSB +: BANK_SEL_W];
   assign word_sel = addr_i[WORD_LSB +: WORD_W];

   assign start = (state == dec_idle) && req_i;

   // one access in flight, held until the collector releases it
   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         state <= dec_idle;
      end else begin
         case (state)
            dec_idle: begin
               if (req_i) begin
                  state <= dec_busy;
               end
            end
            dec_busy: begin
               if (release_i) begin
                  state <= dec_idle;
               end
            end
            default: state <= dec_idle;
         endcase
      end
   end

   // enable and miss are single-cycle pulses
   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         bank_en_o <= '0;
         miss_o    <= 1'b0;
      end else begin
         bank_en_o <= '0;
         miss_o    <= 1'b0;
         if (start) begin
            if (mapped) begin
               bank_en_o[bank_sel] <= 1'b1;
            end else begin
               miss_o <= 1'b1;
            end
         end
      end
   end

   // shared bank payload
   always_ff @(posedge mig_clk) begin
      if (start) begin
         bank_word_o  <= word_sel;
         bank_wdata_o <= wdata_i;
         bank_we_o    <= (op_i == op_write) ? strb_i : '0;  // no lanes on a read
      end
   end

endmodule

// ==== hw/bram_bank.sv ====
// byte-strobed single-port block RAM bank with registered read
`timescale 1ns/100ps

module bram_bank import mem_pkg::*; (
   input  logic      mig_clk,
   input  logic      rst_i,
   input  logic      en_i,
   input  strb_t     we_i,
   input  word_idx_t word_i,
   input  data_t     wdata_i,
   output data_t     rdata_o,
   output logic      valid_o
);

   data_t mem [WORDS_PER_BANK];

   // read port returns the word as it was before this access
   always_ff @(posedge mig_clk) begin
      if (en_i) begin
         rdata_o <= mem[word_i];
      end
   end

   // per-lane write
   always_ff @(posedge mig_clk) begin
      if (en_i) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (we_i[i]) begin
               mem[word_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= en_i;  // one cycle after the enable
      end
   end

endmodule

// ==== hw/mem_pkg.sv ====
// memory path package with the address map, widths and shared enums
package mem_pkg;

   // widths
   localparam int ADDR_W         = 16;
   localparam int DATA_W         = 32;
   localparam int STRB_W         = DATA_W / 8;

   // bank geometry
   localparam int N_BANKS        = 4;
   localparam int WORDS_PER_BANK = 256;

   // address fields, bits 1:0 are the byte offset and are ignored
   localparam int BANK_SEL_LSB   = 12;
   localparam int BANK_SEL_W     = 2;  // bits 13:12
   localparam int WORD_LSB       = 2;
   localparam int WORD_W         = 8;  // bits 9:2

   // must be zero for a mapped address: bits 15, 14, 11, 10
   localparam logic [ADDR_W-1:0] MAP_MASK = 16'hcc00;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [STRB_W-1:0]     strb_t;
   typedef logic [BANK_SEL_W-1:0] bank_idx_t;
   typedef logic [WORD_W-1:0]     word_idx_t;

   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } mem_op_e;

   // same codes as the bus resp field
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_decerr = 2'b11
   } resp_e;

   typedef enum logic {
      dec_idle = 1'b0,
      dec_busy = 1'b1
   } dec_state_e;

   typedef enum logic {
      ack_low  = 1'b0,
      ack_high = 1'b1
   } ack_state_e;

endpackage

// ==== hw/mem_subsys_top.sv ====
// on-chip memory subsystem top, decoder feeding the bank array and the collector
`timescale 1ns/100ps

module mem_subsys_top import mem_pkg::*; (
   input  logic    mig_clk,
   input  logic    rst_i,
   input  logic    req_i,
   input  mem_op_e op_i,
   input  addr_t   addr_i,
   input  data_t   wdata_i,
   input  strb_t   strb_i,
   output logic    ack_o,
   output resp_e   resp_o,
   output data_t   rdata_o
);

   // decoder to banks
   logic [N_BANKS-1:0] bank_en;
   strb_t              bank_we;
   word_idx_t          bank_word;
   data_t              bank_wdata;
   logic               miss;

   // banks to collector
   logic [N_BANKS-1:0] bank_valid;
   data_t              bank_rdata [N_BANKS];

   logic               release_p;  // collector back to decoder

   bank_decoder u_decoder (
      .mig_clk      ( mig_clk    ),
      .rst_i        ( rst_i      ),
      .req_i        ( req_i      ),
      .op_i         ( op_i       ),
      .addr_i       ( addr_i     ),
      .wdata_i      ( wdata_i    ),
      .strb_i       ( strb_i     ),
      .release_i    ( release_p  ),
      .bank_en_o    ( bank_en    ),
      .bank_we_o    ( bank_we    ),
      .bank_word_o  ( bank_word  ),
      .bank_wdata_o ( bank_wdata ),
      .miss_o       ( miss       )
   );

   for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
      bram_bank u_bank (
         .mig_clk ( mig_clk       ),
         .rst_i   ( rst_i         ),
         .en_i    ( bank_en[g]    ),
         .we_i    ( bank_we       ),
         .word_i  ( bank_word     ),
         .wdata_i ( bank_wdata    ),
         .rdata_o ( bank_rdata[g] ),
         .valid_o ( bank_valid[g] )
      );
   end

   resp_collector u_collector (
      .mig_clk      ( mig_clk    ),
      .rst_i        ( rst_i      ),
      .req_i        ( req_i      ),
      .bank_valid_i ( bank_valid ),
      .bank_rdata_i ( bank_rdata ),
      .miss_i       ( miss       ),
      .ack_o        ( ack_o      ),
      .resp_o       ( resp_o     ),
      .rdata_o      ( rdata_o    ),
      .release_o    ( release_p  )
   );

endmodule

// ==== hw/resp_collector.sv ====
// response collector, picks the bank result or miss and drives the ack handshake
`timescale 1ns/100ps

module resp_collector import mem_pkg::*; (
   input  logic               mig_clk,
   input  logic               rst_i,
   input  logic               req_i,
   input  logic [N_BANKS-1:0] bank_valid_i,
   input  data_t              bank_rdata_i [N_BANKS],
   input  logic               miss_i,
   output logic               ack_o,
   output resp_e              resp_o,
   output data_t              rdata_o,
   output logic               release_o
);

   ack_state_e state;
   logic       miss_d;
   logic       done;
   data_t      rdata_sel;

   // miss is one cycle ahead of a bank valid
   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         miss_d <= 1'b0;
      end else begin
         miss_d <= miss_i;
      end
   end

   assign done = (|bank_valid_i) || miss_d;

   // at most one bank is valid, so an or of the masked words is enough
   always_comb begin
      rdata_sel = '0;
      for (int i = 0; i < N_BANKS; i++) begin
         if (bank_valid_i[i]) begin
            rdata_sel = rdata_sel | bank_rdata_i[i];
         end
      end
   end

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         state     <= ack_low;
         release_o <= 1'b0;
      end else begin
         release_o <= 1'b0;
         case (state)
            ack_low: begin
               if (done) begin
                  state <= ack_high;
               end
            end
            ack_high: begin
               if (!req_i) begin
                  state     <= ack_low;
                  release_o <= 1'b1;  // frees the decoder
               end
            end
            default: state <= ack_low;
         endcase
      end
   end

   // held for the whole ack phase
   always_ff @(posedge mig_clk) begin
      if (state == ack_low && done) begin
         resp_o  <= miss_d ? resp_decerr : resp_okay;
         rdata_o <= rdata_sel;
      end
   end

   assign ack_o = (state == ack_high);

endmodule

// ==== project.f ====
hw/mem_pkg.sv
hw/bank_decoder.sv
hw/bram_bank.sv
hw/resp_collector.sv
hw/mem_subsys_top.sv
testbench/mem_subsys_checker.sv
testbench/tb_mem_subsys.sv

// ==== testbench/mem_subsys_checker.sv ====
// protocol checker for the memory subsystem, handshake and bank enable assertions
`timescale 1ns/100ps

module mem_subsys_checker import mem_pkg::*; (
   input logic               mig_clk,
   input logic               rst_i,
   input logic               req_i,
   input logic               ack_i,
   input resp_e              resp_i,
   input logic [N_BANKS-1:0] bank_en_i
);

   int unsigned assert_fails = 0;  // read by the testbench

   a_ack_rise: assert property (@(posedge mig_clk) disable iff (rst_i)
      $rose(ack_i) |-> req_i)
   else begin
      $error("ack rose without a request");
      assert_fails++;
   end

   // ack only falls once the master has let go
   a_ack_hold: assert property (@(posedge mig_clk) disable iff (rst_i)
      (ack_i && req_i) |=> ack_i)
   else begin
      $error("ack dropped while the request was still high");
      assert_fails++;
   end

   a_resp_stable: assert property (@(posedge mig_clk) disable iff (rst_i)
      (ack_i && $past(ack_i)) |-> $stable(resp_i))
   else begin
      $error("response changed during the ack phase");
      assert_fails++;
   end

   a_bank_onehot: assert property (@(posedge mig_clk) disable iff (rst_i)
      $onehot0(bank_en_i))
   else begin
      $error("more than one bank enabled");
      assert_fails++;
   end

endmodule

bind mem_subsys_top mem_subsys_checker u_checker (
   .mig_clk   ( mig_clk ),
   .rst_i     ( rst_i   ),
   .req_i     ( req_i   ),
   .ack_i     ( ack_o   ),
   .resp_i    ( resp_o  ),
   .bank_en_i ( bank_en )
);

// ==== testbench/tb_mem_subsys.sv ====
// testbench running directed and random accesses on the memory subsystem against a word model
`timescale 1ns/100ps

module tb_mem_subsys import mem_pkg::*; ();

   localparam int     CLK_PERIOD  = 100;
   localparam int     N_FILL      = N_BANKS * WORDS_PER_BANK;
   localparam int     N_BASIC     = N_BANKS * 4;
   localparam int     N_STRB      = 8;
   localparam int     N_UNMAPPED  = 12;
   localparam int     N_CROSS     = N_BANKS * 2;
   localparam int     N_RANDOM    = 200;
   localparam int     N_OPS       = N_FILL + N_BASIC + N_STRB + N_UNMAPPED + N_CROSS + N_RANDOM;
   localparam longint WATCHDOG_NS = longint'(N_OPS) * 10 * CLK_PERIOD + 50 * CLK_PERIOD;

   logic    mig_clk;
   logic    rst_i;
   logic    req;
   mem_op_e op;
   addr_t   addr;
   data_t   wdata;
   strb_t   strb;
   logic    ack;
   resp_e   resp;
   data_t   rdata;

   data_t model [N_BANKS][WORDS_PER_BANK];  // expected bank contents

   resp_e exp_resp_q [$];
   data_t exp_data_q [$];
   bit    exp_read_q [$];

   int unsigned errors = 0;
   int unsigned checks = 0;
   int unsigned tests_run = 0;
   int unsigned tests_failed = 0;
   int unsigned errs_at_start;
   string       cur_test;
   logic        ack_q;

   mem_subsys_top u_dut (
      .mig_clk ( mig_clk ),
      .rst_i   ( rst_i   ),
      .req_i   ( req     ),
      .op_i    ( op      ),
      .addr_i  ( addr    ),
      .wdata_i ( wdata   ),
      .strb_i  ( strb    ),
      .ack_o   ( ack     ),
      .resp_o  ( resp    ),
      .rdata_o ( rdata   )
   );

   initial mig_clk = 1'b0;
   always #(CLK_PERIOD / 2) mig_clk = ~mig_clk;

   // bank from bits 13:12 and word from bits 9:2 once bits 15, 14, 11 and 10 are clear
   function automatic void ref_access(input mem_op_e f_op, input addr_t f_addr,
                                      input data_t f_wdata, input strb_t f_strb,
                                      output resp_e f_resp, output data_t f_rdata);
      int b;
      int w;
      f_rdata = '0;
      if (f_addr[15] || f_addr[14] || f_addr[11] || f_addr[10]) begin
         f_resp = resp_decerr;
         return;
      end
      b       = f_addr[13:12];
      w       = f_addr[9:2];
      f_resp  = resp_okay;
      f_rdata = model[b][w];  // pre-write contents
      if (f_op == op_write) begin
         for (int i = 0; i < 4; i++) begin
            if (f_strb[i]) begin
               model[b][w][i*8 +: 8] = f_wdata[i*8 +: 8];
            end
         end
      end
   endfunction

   function automatic addr_t mapped_addr(input int bank, input int word);
      addr_t a;
      a = '0;
      a[13:12] = bank[1:0];
      a[9:2]   = word[7:0];
      return a;
   endfunction

   function automatic int unsigned total_errors();
      return errors + u_dut.u_checker.assert_fails;
   endfunction

   task automatic check_resp(input resp_e got, input resp_e exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s response %s, expected %s",
                  $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_data(input data_t got, input data_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s 0x%h, expected 0x%h", $time, what, got, exp);
      end
   endtask

   task automatic start_test(input string name);
      cur_test      = name;
      errs_at_start = total_errors();
   endtask

   task automatic end_test();
      int unsigned n;
      n = total_errors() - errs_at_start;
      tests_run++;
      if (n == 0) begin
         $display("%-26s ok", cur_test);
      end else begin
         tests_failed++;
         $display("%-26s %0d error(s)", cur_test, n);
      end
   endtask

   // one full four-phase handshake with the expected result queued at issue
   task automatic access(input mem_op_e a_op, input addr_t a_addr,
                         input data_t a_wdata, input strb_t a_strb);
      resp_e e_resp;
      data_t e_data;
      ref_access(a_op, a_addr, a_wdata, a_strb, e_resp, e_data);
      exp_resp_q.push_back(e_resp);
      exp_data_q.push_back(e_data);
      exp_read_q.push_back(a_op == op_read && e_resp == resp_okay);
      @(posedge mig_clk);
      req   <= 1'b1;
      op    <= a_op;
      addr  <= a_addr;
      wdata <= a_wdata;
      strb  <= a_strb;
      do @(posedge mig_clk); while (ack !== 1'b1);
      req <= 1'b0;
      do @(posedge mig_clk); while (ack !== 1'b0);
   endtask

   // compares each response as ack rises
   always @(posedge mig_clk) begin : compare
      resp_e e_resp;
      data_t e_data;
      bit    e_read;
      if (rst_i) begin
         ack_q = 1'b0;
      end else begin
         if (ack === 1'b1 && ack_q !== 1'b1) begin
            if (exp_resp_q.size() == 0) begin
               errors++;
               $display("ack at %0t ns with no access outstanding", $time);
            end else begin
               e_resp = exp_resp_q.pop_front();
               e_data = exp_data_q.pop_front();
               e_read = exp_read_q.pop_front();
               check_resp(resp, e_resp, "access");
               if (e_read) begin
                  check_data(rdata, e_data, "read data");
               end
            end
         end
         ack_q = ack;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: the accesses did not complete within %0d ns", WATCHDOG_NS);
      $display("TEST FAIL");
      $finish;
   end

   initial begin : stimulus
      int unsigned seed_dummy;
      addr_t       a;
      data_t       d;
      strb_t       strb_set [4];
      addr_t       bad_bits [4];
      seed_dummy = $urandom(32'h388b_48a5);
      strb_set   = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
      bad_bits   = '{16'h8000, 16'h4000, 16'h0800, 16'h0400};
      rst_i = 1'b1;
      req   = 1'b0;
      op    = op_read;
      addr  = '0;
      wdata = '0;
      strb  = '0;
      repeat (2) @(posedge mig_clk);
      rst_i <= 1'b0;

      start_test("idle after reset");
      repeat (8) begin
         @(posedge mig_clk);
         if (ack !== 1'b0) begin
            errors++;
            $display("ack was high at %0t ns with no request", $time);
         end
      end
      end_test();

      start_test("fill all banks");
      for (int i = 0; i < N_FILL; i++) begin
         a = mapped_addr(i / WORDS_PER_BANK, i % WORDS_PER_BANK);
         access(op_write, a, {~a, a}, 4'hf);
      end
      end_test();

      start_test("write then read per bank");
      for (int b = 0; b < N_BANKS; b++) begin
         for (int k = 0; k < 2; k++) begin
            a = mapped_addr(b, $urandom % WORDS_PER_BANK);
            d = $urandom;
            access(op_write, a, d, 4'hf);
            access(op_read, a, '0, 4'h0);
         end
      end
      end_test();

      start_test("partial strobes");
      a = mapped_addr(1, 8'h3c);
      for (int k = 0; k < 4; k++) begin
         access(op_write, a, $urandom, strb_set[k]);
         access(op_read, a, '0, 4'h0);
      end
      end_test();

      start_test("unmapped addresses");
      for (int k = 0; k < 4; k++) begin
         a = mapped_addr(k, 5 * k);
         access(op_write, a | bad_bits[k], 32'hdead_beef, 4'hf);
         access(op_read, a | bad_bits[k], '0, 4'h0);
         access(op_read, a, '0, 4'h0);  // alias untouched
      end
      end_test();

      start_test("same word across banks");
      for (int b = 0; b < N_BANKS; b++) begin
         access(op_write, mapped_addr(b, 8'h77), 32'h1111_1111 * (b + 1), 4'hf);
      end
      for (int b = 0; b < N_BANKS; b++) begin
         access(op_read, mapped_addr(b, 8'h77), '0, 4'h0);
      end
      end_test();

      start_test("random accesses");
      for (int k = 0; k < N_RANDOM; k++) begin
         a = addr_t'($urandom);
         if ($urandom % 4 != 0) begin
            a = a & 16'h33ff;  // mostly mapped
         end
         access(mem_op_e'($urandom % 2), a, $urandom, strb_t'($urandom));
      end
      end_test();

      repeat (4) @(posedge mig_clk);
      if (exp_resp_q.size() != 0) begin
         errors++;
         $display("%0d responses never arrived", exp_resp_q.size());
      end
      $display("tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, total_errors());
      if (total_errors() == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
